// ==== logic/stim_pkg.sv ====
// stimulus engine shared definitions
`default_nettype none

package stim_pkg;

   // ##################################################
   // widths and depths
   // ##################################################
   localparam int payload_w  = 32;                   // packet payload
   localparam int ctrl_w     = 8;                    // per-entry control word
   localparam int entry_w    = payload_w + ctrl_w;   // one memory entry
   localparam int mem_depth  = 64;                   // stimulus entries
   localparam int mem_aw     = $clog2(mem_depth);    // 6 bits
   localparam int fifo_depth = 4;                    // output decoupling
   localparam int count_w    = 16;                   // delivered packet counter
   localparam int crc_w      = 32;

   // ##################################################
   // entry layout, control in the low byte
   // ##################################################
   localparam int ctrl_valid_bit = 0;                // clear marks end of stream
   localparam int ctrl_delay_lsb = 1;                // idle cycles after packet
   localparam int delay_w        = ctrl_w - 1;       // bits 7:1

   // crc-32, reflected form, shifted lsb first
   localparam logic [crc_w-1:0] crc_poly = 32'hEDB8_8320;
   localparam logic [crc_w-1:0] crc_init = 32'hFFFF_FFFF; // no final xor applied

   typedef logic [payload_w-1:0] payload_t;
   typedef logic [entry_w-1:0]   entry_t;            // payload in [39:8]

   // read sequencer states
   typedef enum logic [1:0]
   {
      st_idle   = 2'b00,   // waiting for go
      st_active = 2'b01,   // presenting fetched entry
      st_pause  = 2'b10,   // inserting idle cycles
      st_done   = 2'b11    // end marker seen
   } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/stim_dpram.sv ====
// two-clock stimulus memory
`timescale 1ns/10ps
`default_nettype none

module stim_dpram
   import stim_pkg::*;
   #(
   parameter type item_t = logic
   )
   (
   input  wire              ext_clk,    // load side clock
   input  wire              nreset,     // async, active low
   input  wire              load,       // allows address to advance
   input  wire              ext_valid,  // write strobe
   input  wire item_t       ext_entry,
   input  wire              dut_clk,    // read side clock
   input  wire [mem_aw-1:0] rd_addr,
   output item_t            rd_entry    // one cycle after rd_addr
   );

   item_t             ram [mem_depth];
   logic [mem_aw-1:0] wr_addr;          // only moves forward

   // ##################################################
   // write port, ext_clk domain
   // ##################################################
   always_ff @(posedge ext_clk or negedge nreset)
   begin
      if (!nreset)
         wr_addr <= '0;
      else if (ext_valid && load)
         wr_addr <= wr_addr + 1'b1;   // one beat per entry
   end

   always_ff @(posedge ext_clk)
   begin
      if (ext_valid)
         ram[wr_addr] <= ext_entry;
   end

   // registered read, dut_clk domain
   always_ff @(posedge dut_clk)
   begin
      rd_entry <= ram[rd_addr];
   end

endmodule

`default_nettype wire

// ==== logic/stim_sequencer.sv ====
// stimulus read sequencer
`timescale 1ns/10ps
`default_nettype none

module stim_sequencer
   import stim_pkg::*;
   (
   input  wire               dut_clk,
   input  wire               nreset,      // async, active low
   input  wire               go,          // async start level
   input  wire entry_t       rd_entry,    // entry at addr_q
   input  wire               fifo_ready,
   output logic [mem_aw-1:0] rd_addr,     // lookahead address to memory
   output logic              seq_valid,
   output payload_t          seq_payload,
   output logic              seq_done
   );

   logic [1:0]         go_sync;        // two flop synchronizer
   logic               go_s;
   seq_state_t         state;
   logic [mem_aw-1:0]  addr_q;         // entry being presented
   logic [delay_w-1:0] delay_cnt;      // idle cycles left
   logic               entry_valid;
   logic [delay_w-1:0] entry_delay;
   logic               xfer;           // handshake into fifo

   // ##################################################
   // go synchronizer
   // ##################################################
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         go_sync <= '0;
      else
         go_sync <= {go_sync[0], go};
   end

   assign go_s = go_sync[1];

   // ##################################################
   // entry decode and handshake
   // ##################################################
   assign entry_valid = rd_entry[ctrl_valid_bit];
   assign entry_delay = rd_entry[ctrl_delay_lsb +: delay_w];
   assign seq_payload = rd_entry[entry_w-1 -: payload_w];   // upper bits

   // valid from state and registered entry only, never from ready
   assign seq_valid = (state == st_active) && entry_valid;
   assign xfer      = seq_valid && fifo_ready;
   assign seq_done  = (state == st_done);

   // memory has one cycle latency
   // so present next address in the transfer cycle
   assign rd_addr = xfer ? addr_q + 1'b1 : addr_q;

   // ##################################################
   // read state machine
   // ##################################################
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state     <= st_idle;
         addr_q    <= '0;
         delay_cnt <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (go_s)
                  state <= st_active;     // entry 0 already fetched
            end
            st_active:
            begin
               if (!entry_valid)
                  state <= st_done;       // end marker
               else if (xfer)
               begin
                  addr_q    <= rd_addr;
                  delay_cnt <= entry_delay;
                  if (entry_delay != '0)
                     state <= st_pause;
               end
               // no transfer: hold packet and address
            end
            st_pause:
            begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == delay_w'(1))
                  state <= st_active;     // last idle cycle
            end
            default:
            begin
               state <= st_done;          // parked until reset
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/stim_fifo.sv ====
// output decoupling fifo
`timescale 1ns/10ps
`default_nettype none

module stim_fifo
   import stim_pkg::*;
   #(
   parameter type item_t = logic,
   parameter int  depth  = fifo_depth
   )
   (
   input  wire        dut_clk,
   input  wire        nreset,     // async, active low
   input  wire        in_valid,
   input  wire item_t in_data,
   input  wire        out_ready,
   output logic       in_ready,   // low when full
   output logic       out_valid,
   output item_t      out_data,
   output logic       empty
   );

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   item_t            mem [depth];   // storage, no reset
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;         // occupancy
   logic             push;
   logic             pop;

   assign in_ready  = (count != cnt_w'(depth));
   assign out_valid = (count != '0);
   assign empty     = (count == '0);
   assign out_data  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge dut_clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   // ##################################################
   // pointers and occupancy
   // ##################################################
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;   // both together: unchanged
      end
   end

endmodule

`default_nettype wire

// ==== logic/stim_signature.sv ====
// output signature monitor
`timescale 1ns/10ps
`default_nettype none

module stim_signature
   import stim_pkg::*;
   (
   input  wire                dut_clk,
   input  wire                nreset,       // async, active low
   input  wire                out_valid,
   input  wire                out_ready,
   input  wire payload_t      out_payload,
   input  wire                seq_done,     // end marker reached
   input  wire                fifo_empty,
   output logic [count_w-1:0] pkt_count,
   output logic [crc_w-1:0]   crc,          // running, not inverted
   output logic               run_done      // sticky
   );

   logic xfer;

   // one payload folded in, bit 0 first
   function automatic logic [crc_w-1:0] crc_step
   (
      input logic [crc_w-1:0] c_in,
      input payload_t         d
   );
      logic [crc_w-1:0] c;
      logic             fb;
      c = c_in;
      for (int i = 0; i < payload_w; i++)
      begin
         fb = c[0] ^ d[i];
         c  = c >> 1;
         if (fb)
            c = c ^ crc_poly;
      end
      return c;
   endfunction

   assign xfer = out_valid && out_ready;

   // ##################################################
   // count, crc and completion
   // ##################################################
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pkt_count <= '0;
         crc       <= crc_init;
         run_done  <= 1'b0;
      end
      else
      begin
         if (xfer)
         begin
            pkt_count <= pkt_count + 1'b1;
            crc       <= crc_step(crc, out_payload);
         end
         if (seq_done && fifo_empty)
            run_done <= 1'b1;   // stream over and drained
      end
   end

endmodule

`default_nettype wire

// ==== logic/stim_subsystem_top.sv ====
// stimulus subsystem top
`timescale 1ns/10ps
`default_nettype none

module stim_subsystem_top
   import stim_pkg::*;
   (
   input  wire                nreset,      // async, active low
   input  wire                load,
   input  wire                go,
   // load port, ext_clk domain
   input  wire                ext_clk,
   input  wire                ext_valid,
   input  wire entry_t        ext_entry,
   // stream out, dut_clk domain
   input  wire                dut_clk,
   input  wire                out_ready,
   output logic               out_valid,
   output payload_t           out_payload,
   // signature
   output logic [count_w-1:0] pkt_count,
   output logic [crc_w-1:0]   crc,
   output logic               run_done
   );

   logic [mem_aw-1:0] rd_addr;
   entry_t            rd_entry;
   logic              seq_valid;
   payload_t          seq_payload;
   logic              seq_done;
   logic              fifo_ready;
   logic              fifo_empty;

   // ##################################################
   // memory and read side
   // ##################################################
   stim_dpram #(.item_t(entry_t)) u_dpram
   (
      .ext_clk   (ext_clk),
      .nreset    (nreset),
      .load      (load),
      .ext_valid (ext_valid),
      .ext_entry (ext_entry),
      .dut_clk   (dut_clk),
      .rd_addr   (rd_addr),
      .rd_entry  (rd_entry)
   );

   stim_sequencer u_seq
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .go          (go),
      .rd_entry    (rd_entry),
      .fifo_ready  (fifo_ready),
      .rd_addr     (rd_addr),
      .seq_valid   (seq_valid),
      .seq_payload (seq_payload),
      .seq_done    (seq_done)
   );

   // ##################################################
   // output path and monitor
   // ##################################################
   stim_fifo #(.item_t(payload_t), .depth(fifo_depth)) u_fifo
   (
      .dut_clk   (dut_clk),
      .nreset    (nreset),
      .in_valid  (seq_valid),
      .in_data   (seq_payload),
      .out_ready (out_ready),
      .in_ready  (fifo_ready),
      .out_valid (out_valid),
      .out_data  (out_payload),
      .empty     (fifo_empty)
   );

   stim_signature u_sig
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_payload (out_payload),
      .seq_done    (seq_done),
      .fifo_empty  (fifo_empty),
      .pkt_count   (pkt_count),
      .crc         (crc),
      .run_done    (run_done)
   );

endmodule

`default_nettype wire

// ==== dv/tb_stim_subsystem.sv ====
// stimulus subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module tb_stim_subsystem
   import stim_pkg::*;
   ();

   logic               dut_clk = 1'b0;
   logic               ext_clk = 1'b0;
   logic               nreset;
   logic               load;
   logic               go;
   logic               ext_valid;
   entry_t             ext_entry;
   logic               out_ready;
   logic               out_valid;
   payload_t           out_payload;
   logic [count_w-1:0] pkt_count;
   logic [crc_w-1:0]   crc;
   logic               run_done;

   entry_t             load_q [$];      // L lines
   payload_t           exp_q [$];       // E lines, delivery order
   logic [crc_w-1:0]   exp_crc;
   bit                 vectors_ok;
   int                 errors = 0;
   int                 checks = 0;
   int                 cycles = 0;
   int                 cycle_limit = 200;
   int                 got_cnt = 0;     // output transfers seen

   always #10 dut_clk = ~dut_clk;      // 20 ns
   always #15 ext_clk = ~ext_clk;      // 30 ns, unrelated to dut_clk

   stim_subsystem_top UUT
   (
      .nreset      (nreset),
      .load        (load),
      .go          (go),
      .ext_clk     (ext_clk),
      .ext_valid   (ext_valid),
      .ext_entry   (ext_entry),
      .dut_clk     (dut_clk),
      .out_ready   (out_ready),
      .out_valid   (out_valid),
      .out_payload (out_payload),
      .pkt_count   (pkt_count),
      .crc         (crc),
      .run_done    (run_done)
   );

   // ##################################################
   // helpers
   // ##################################################
   task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("[FAIL] %0d ns: %s: got %h, expected %h", $time, msg, actual, expected);
      end
   endtask

   // reflected crc-32, data bit 0 enters first
   function automatic logic [crc_w-1:0] crc_fold(input logic [crc_w-1:0] c_in,
                                                 input payload_t word);
      logic [crc_w-1:0] c;
      payload_t         w;
      c = c_in;
      w = word;
      repeat (payload_w)
      begin
         if ((c[0] ^ w[0]) == 1'b1)
            c = (c >> 1) ^ crc_poly;
         else
            c = c >> 1;
         w = w >> 1;   // next data bit down
      end
      return c;
   endfunction

   task automatic end_run(input bit timed_out);
      $display("errors: %0d, checks: %0d, packets: %0d of %0d",
               errors, checks, got_cnt, exp_q.size());
      if (errors == 0 && !timed_out)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   endtask

   task automatic read_vectors(output bit ok);
      int          fd;
      int          r;
      string       line;
      byte         tag;
      logic [39:0] v;
      ok = 1'b0;
      fd = $fopen("dv/stim_vectors.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("cannot open the vector file dv/stim_vectors.txt");
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            r = $fgets(line, fd);
            if (r > 0 && line.len() > 1)
            begin
               tag = line[0];   // '#' lines skipped
               if (tag == "L" || tag == "E")
               begin
                  r = $sscanf(line.substr(1, line.len() - 1), "%h", v);
                  if (r != 1)
                  begin
                     errors++;
                     $display("vector line has no readable value: %s", line);
                  end
                  else if (tag == "L")
                     load_q.push_back(v);
                  else
                     exp_q.push_back(v[31:0]);
               end
            end
         end
         $fclose(fd);
         if (load_q.size() == 0 || load_q.size() > mem_depth || exp_q.size() == 0)
         begin
            errors++;
            $display("vector file holds %0d entries and %0d expected packets, cannot run",
                     load_q.size(), exp_q.size());
         end
         else
            ok = 1'b1;
      end
   endtask

   // nothing may move before go
   task automatic check_idle(input string when);
      compare(out_valid, 1'b0, {"out_valid ", when});
      compare(run_done, 1'b0, {"run_done ", when});
      compare(pkt_count, '0, {"pkt_count ", when});
      compare(crc, 32'hFFFF_FFFF, {"crc ", when});
   endtask

   // one entry per falling ext_clk edge
   task automatic load_memory();
      @(negedge ext_clk);
      load = 1'b1;
      foreach (load_q[i])
      begin
         ext_entry = load_q[i];
         ext_valid = 1'b1;
         @(negedge ext_clk);
      end
      ext_valid = 1'b0;
      load      = 1'b0;
   endtask

   // ready drawn at negedge, so out_valid and out_ready already show the next posedge
   task automatic stream_packets();
      bit finished;
      finished = 1'b0;
      while (!finished)
      begin
         @(negedge dut_clk);
         if (run_done)
            finished = 1'b1;
         else
         begin
            out_ready = (($urandom % 100) < 70);   // about 70 percent
            if (out_valid && out_ready)
            begin
               if (got_cnt >= exp_q.size())
               begin
                  errors++;
                  $display("%0d ns: packet %h delivered after the expected stream ended",
                           $time, out_payload);
               end
               else
                  compare(out_payload, exp_q[got_cnt],
                          $sformatf("packet %0d payload", got_cnt));
               got_cnt++;
            end
         end
      end
   endtask

   // reset, load, go, stream and final signature
   task automatic run_checks();
      cycle_limit = 20 * load_q.size() + 200;
      exp_crc = 32'hFFFF_FFFF;
      foreach (exp_q[i])
         exp_crc = crc_fold(exp_crc, exp_q[i]);

      repeat (3) @(negedge dut_clk);
      nreset = 1'b1;
      check_idle("after reset");

      load_memory();
      @(negedge dut_clk);
      check_idle("after load, before go");
      go = 1'b1;   // synchronized inside

      stream_packets();
      compare(got_cnt, exp_q.size(), "transfers before run_done");
      compare(pkt_count, exp_q.size(), "pkt_count at run_done");
      compare(crc, exp_crc, "crc at run_done");

      // done is sticky and the output stays quiet
      repeat (20)
      begin
         @(negedge dut_clk);
         out_ready = (($urandom % 100) < 70);
         compare(run_done, 1'b1, "run_done held");
         compare(out_valid, 1'b0, "out_valid after run_done");
      end
   endtask

   // ##################################################
   // watchdog
   // ##################################################
   initial
   begin
      do
      begin
         @(posedge dut_clk);
         cycles = cycles + 1;
      end
      while (cycles < cycle_limit);
      $display("timeout: run_done did not rise within %0d dut_clk cycles", cycle_limit);
      end_run(1'b1);
   end

   // ##################################################
   // main sequence
   // ##################################################
   initial
   begin
      void'($urandom(59769));   // single seed for the run
      nreset    = 1'b0;
      load      = 1'b0;
      go        = 1'b0;
      ext_valid = 1'b0;
      ext_entry = '0;
      out_ready = 1'b0;

      read_vectors(vectors_ok);
      if (vectors_ok)
         run_checks();
      end_run(1'b0);
   end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/stim_pkg.sv
logic/stim_dpram.sv
logic/stim_sequencer.sv
logic/stim_fifo.sv
logic/stim_signature.sv
logic/stim_subsystem_top.sv
dv/tb_stim_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stimulus subsystem testbench with verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
   --top-module tb_stim_subsystem \
   -f compile.f \
   --Mdir obj_dir -o tb_stim_subsystem

./obj_dir/tb_stim_subsystem | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
   echo "simulation passed, log in sim.log"
else
   echo "simulation failed, log in sim.log"
   exit 1
fi

// ==== dv/stim_vectors.txt ====
# L <40-bit entry hex>: payload [39:8], control [7:0] (bit 0 valid, bits 7:1 idle cycles)
# E <32-bit payload hex>: expected delivered payload, in order
L 1234567801
L 89ABCDEF07
L 0000000001
L FFFFFFFF03
L A5A5A5A501
L 5A5A5A5A0B
L DEADBEEF01
L CAFEF00D05
L 0F0F0F0F01
L 13579BDF21
L 2468ACE001
L 0000000000
L BAD0000101
L BAD0000201
E 12345678
E 89ABCDEF
E 00000000
E FFFFFFFF
E A5A5A5A5
E 5A5A5A5A
E DEADBEEF
E CAFEF00D
E 0F0F0F0F
E 13579BDF
E 2468ACE0
